// File: verilog/uart_pkg.sv
// uart package with register map, bus request, control word and receiver byte types
`default_nettype none

package uart_pkg;

    localparam int addr_w = 2;                          // register address width
    localparam int data_w = 16;                         // bus data width

    localparam logic [addr_w-1:0] addr_cr    = 2'd0;    // control and status
    localparam logic [addr_w-1:0] addr_bauds = 2'd1;    // baud compare value
    localparam logic [addr_w-1:0] addr_txd   = 2'd2;    // transmit data
    localparam logic [addr_w-1:0] addr_rxd   = 2'd3;    // receive data

    // single-cycle access from the bus master
    typedef struct packed {
        logic              sel;
        logic              we;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } uart_bus_req_t;

    typedef struct packed {
        logic [10:0] reserved;
        logic        frame_err;                         // sticky, write 1 clears
        logic        rx_valid;                          // cleared by rxd read
        logic        tx_busy;                           // read only
        logic        rx_en;
        logic        tx_en;
    } uart_cr_t;

    typedef union packed {
        logic [data_w-1:0] raw;                         // bus view
        uart_cr_t          fields;                      // logic view
    } uart_cr_u;

    typedef struct packed {
        logic       valid;                              // one cycle per frame
        logic       frame_err;                          // stop bit was low
        logic [7:0] data;
    } uart_rx_byte_t;

endpackage

`default_nettype wire

// File: verilog/uart_transmitter.sv
// uart transmitter sending one 8N1 frame per four-phase req/ack exchange
`timescale 1ns/1ns
`default_nettype none

module uart_transmitter
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        tr_en,      // transmitter enable
    input  logic [15:0] comp,       // bit length minus one
    input  logic [7:0]  tx_data,    // byte to send
    input  logic        req,        // request from register block
    output logic        req_ack,    // frame done, held until req drops
    output logic        uart_tx     // serial line
);

    typedef enum logic [2:0] { idle_s, start_s, trans_s, stop_s, wait_s } tx_state_t;

    tx_state_t   state;
    logic [15:0] baud_cnt;          // cycles within the current bit
    logic [2:0]  bit_cnt;           // data bit index
    logic [7:0]  byte_q;            // copy of the byte for the frame
    logic        line_q;            // registered line level
    logic        bit_end;           // last cycle of a bit
    logic        accept;            // request taken in idle

    assign bit_end = (baud_cnt == comp);
    assign accept  = (state == idle_s) && req && tr_en;

    // the line lags the state by one edge, so every bit on the wire is comp + 1 long
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            state    <= idle_s;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            line_q   <= 1'b1;
            req_ack  <= 1'b0;
        end
        else if (!tr_en)
        begin
            state    <= idle_s;     // frame abandoned
            baud_cnt <= '0;
            bit_cnt  <= '0;
            line_q   <= 1'b1;
            req_ack  <= 1'b0;
        end
        else
        begin
            baud_cnt <= bit_end ? '0 : baud_cnt + 16'd1;
            case (state)
                idle_s:
                begin
                    line_q   <= 1'b1;
                    baud_cnt <= '0;
                    if (req)
                    begin
                        state   <= start_s;
                        bit_cnt <= '0;
                    end
                end
                start_s:
                begin
                    line_q <= 1'b0;     // start bit
                    if (bit_end)
                        state <= trans_s;
                end
                trans_s:
                begin
                    line_q <= byte_q[bit_cnt];  // lsb first
                    if (bit_end)
                    begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= stop_s;
                    end
                end
                stop_s:
                begin
                    line_q <= 1'b1;
                    if (bit_end)
                        state <= wait_s;
                end
                wait_s:
                begin
                    line_q   <= 1'b1;
                    baud_cnt <= '0;
                    // ack rises as the stop bit ends on the line
                    if (req_ack && !req)
                    begin
                        state   <= idle_s;
                        req_ack <= 1'b0;
                    end
                    else
                        req_ack <= 1'b1;
                end
                default:
                    state <= idle_s;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            byte_q <= tx_data;
    end

    assign uart_tx = line_q;            // high the edge after a disable

endmodule : uart_transmitter

`default_nettype wire

// File: verilog/uart_receiver.sv
// uart receiver with mid-bit sampling of 8N1 frames and a stop-bit check
`timescale 1ns/1ns
`default_nettype none

module uart_receiver
(
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    rec_en,     // receiver enable
    input  logic [15:0]             comp,       // bit length minus one
    input  logic                    uart_rx,    // serial line, asynchronous
    output uart_pkg::uart_rx_byte_t rx_byte
);

    typedef enum logic [1:0] { idle_s, start_s, recv_s, stop_s } rx_state_t;

    rx_state_t   state;
    logic [1:0]  sync_q;            // two-flop synchronizer
    logic        rx_s;              // synchronized line
    logic        rx_prev;           // for falling edge detect
    logic        fall;
    logic [15:0] baud_cnt;
    logic [2:0]  bit_cnt;
    logic [7:0]  shift_q;           // data bits, lsb first
    logic        bit_end;
    logic        half_end;          // middle of the start bit
    logic        valid_q;
    logic        ferr_q;
    logic [7:0]  data_q;

    assign rx_s     = sync_q[1];
    assign fall     = rx_prev & ~rx_s;
    assign bit_end  = (baud_cnt == comp);
    assign half_end = (baud_cnt == (comp >> 1));

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            sync_q  <= 2'b11;
            rx_prev <= 1'b1;
        end
        else
        begin
            sync_q  <= {sync_q[0], uart_rx};
            rx_prev <= rx_s;
        end
    end

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            state    <= idle_s;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            valid_q  <= 1'b0;
        end
        else if (!rec_en)
        begin
            state    <= idle_s;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            valid_q  <= 1'b0;
        end
        else
        begin
            valid_q  <= 1'b0;
            baud_cnt <= baud_cnt + 16'd1;
            case (state)
                idle_s:
                begin
                    baud_cnt <= '0;
                    if (fall)
                        state <= start_s;
                end
                start_s:
                begin
                    if (half_end)
                    begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_s ? idle_s : recv_s;   // high means a glitch
                    end
                end
                recv_s:
                begin
                    if (bit_end)
                    begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= stop_s;
                    end
                end
                stop_s:
                begin
                    if (bit_end)
                    begin
                        valid_q <= 1'b1;
                        state   <= idle_s;
                    end
                end
                default:
                    state <= idle_s;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == recv_s) && bit_end)
            shift_q <= {rx_s, shift_q[7:1]};
        if ((state == stop_s) && bit_end)
        begin
            data_q <= shift_q;
            ferr_q <= ~rx_s;            // stop bit must be high
        end
    end

    assign rx_byte.valid     = valid_q;
    assign rx_byte.frame_err = ferr_q;
    assign rx_byte.data      = data_q;

endmodule : uart_receiver

`default_nettype wire

// File: verilog/uart_regs.sv
// uart register block with bus decode, tx request handshake and rx data holding
`timescale 1ns/1ns
`default_nettype none

module uart_regs
(
    input  logic                        clk,
    input  logic                        resetn,
    input  uart_pkg::uart_bus_req_t     bus,
    input  logic                        tx_ack,
    input  uart_pkg::uart_rx_byte_t     rx_byte,
    output logic [uart_pkg::data_w-1:0] rdata,
    output logic                        tx_en,
    output logic                        rx_en,
    output logic                        tx_req,
    output logic [7:0]                  tx_data,
    output logic [15:0]                 bauds
);

    uart_pkg::uart_cr_u cr_q;       // stored control and status bits
    uart_pkg::uart_cr_u wr_cr;      // write data seen as control fields
    uart_pkg::uart_cr_u rd_cr;      // read word with live busy bit
    logic [7:0]         rx_data_q;
    logic               tx_busy;
    logic               wr_cr_en;
    logic               wr_bauds;
    logic               wr_txd;
    logic               rd_rxd;
    logic               tx_accept;

    assign wr_cr_en  = bus.sel && bus.we && (bus.addr == uart_pkg::addr_cr);
    assign wr_bauds  = bus.sel && bus.we && (bus.addr == uart_pkg::addr_bauds);
    assign wr_txd    = bus.sel && bus.we && (bus.addr == uart_pkg::addr_txd);
    assign rd_rxd    = bus.sel && !bus.we && (bus.addr == uart_pkg::addr_rxd);

    assign wr_cr.raw = bus.wdata;
    assign tx_en     = cr_q.fields.tx_en;
    assign rx_en     = cr_q.fields.rx_en;
    assign tx_busy   = tx_req | tx_ack;
    assign tx_accept = wr_txd && tx_en && !tx_busy;   // otherwise dropped

    // status updates from hardware win over bus clears in the same cycle
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            cr_q  <= '0;
            bauds <= '0;
        end
        else
        begin
            if (wr_cr_en)
            begin
                cr_q.fields.tx_en <= wr_cr.fields.tx_en;
                cr_q.fields.rx_en <= wr_cr.fields.rx_en;
                if (wr_cr.fields.frame_err)
                    cr_q.fields.frame_err <= 1'b0;
            end
            if (rd_rxd)
                cr_q.fields.rx_valid <= 1'b0;
            if (rx_byte.valid)
            begin
                cr_q.fields.rx_valid <= 1'b1;
                if (rx_byte.frame_err)
                    cr_q.fields.frame_err <= 1'b1;
            end
            if (wr_bauds)
                bauds <= bus.wdata;
        end
    end

    // request side of the four-phase exchange
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
            tx_req <= 1'b0;
        else if (!tx_en)
            tx_req <= 1'b0;     // abort
        else if (tx_req && tx_ack)
            tx_req <= 1'b0;
        else if (tx_accept)
            tx_req <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (tx_accept)
            tx_data <= bus.wdata[7:0];      // stable while req is high
        if (rx_byte.valid)
            rx_data_q <= rx_byte.data;      // overwrites an unread byte
    end

    always_comb
    begin
        rd_cr                = cr_q;
        rd_cr.fields.tx_busy = tx_busy;
    end

    always_comb
    begin
        rdata = '0;
        if (bus.sel)
        begin
            case (bus.addr)
                uart_pkg::addr_cr:    rdata = rd_cr.raw;
                uart_pkg::addr_bauds: rdata = bauds;
                uart_pkg::addr_txd:   rdata = {8'h00, tx_data};
                uart_pkg::addr_rxd:   rdata = {8'h00, rx_data_q};
                default:              rdata = '0;
            endcase
        end
    end

endmodule : uart_regs

`default_nettype wire

// File: verilog/uart_top.sv
// uart top level joining the register block, transmitter and receiver
`timescale 1ns/1ns
`default_nettype none

module uart_top
(
    input  logic                        clk,
    input  logic                        resetn,
    input  uart_pkg::uart_bus_req_t     bus,
    input  logic                        uart_rx,
    output logic [uart_pkg::data_w-1:0] rdata,
    output logic                        uart_tx
);

    logic                    tx_en;
    logic                    rx_en;
    logic                    tx_req;
    logic                    tx_ack;
    logic [7:0]              tx_data;
    logic [15:0]             bauds;         // shared by both engines
    uart_pkg::uart_rx_byte_t rx_byte;

    uart_regs regs_i
    (
        .clk     (clk),
        .resetn  (resetn),
        .bus     (bus),
        .tx_ack  (tx_ack),
        .rx_byte (rx_byte),
        .rdata   (rdata),
        .tx_en   (tx_en),
        .rx_en   (rx_en),
        .tx_req  (tx_req),
        .tx_data (tx_data),
        .bauds   (bauds)
    );

    uart_transmitter tx_i
    (
        .clk     (clk),
        .resetn  (resetn),
        .tr_en   (tx_en),
        .comp    (bauds),
        .tx_data (tx_data),
        .req     (tx_req),
        .req_ack (tx_ack),
        .uart_tx (uart_tx)
    );

    uart_receiver rx_i
    (
        .clk     (clk),
        .resetn  (resetn),
        .rec_en  (rx_en),
        .comp    (bauds),
        .uart_rx (uart_rx),
        .rx_byte (rx_byte)
    );

endmodule : uart_top

`default_nettype wire

// File: test/uart_clk_gen.sv
// clock and reset generator for the uart testbench
`timescale 1ns/1ns
`default_nettype none

module uart_clk_gen
(
    output logic clk,
    output logic resetn
);

    localparam int half_period  = 50;   // 100 ns clock
    localparam int reset_cycles = 5;

    initial
    begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial
    begin
        resetn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #10 resetn = 1'b1;              // released like any other stimulus
    end

endmodule : uart_clk_gen

`default_nettype wire

// File: test/uart_assertions.sv
// protocol checks on the tx handshake, the idle line and the read bus of the uart
`timescale 1ns/1ns
`default_nettype none

module uart_assertions
(
    input logic                        clk,
    input logic                        resetn,
    input uart_pkg::uart_bus_req_t     bus,
    input logic [uart_pkg::data_w-1:0] rdata,
    input logic                        tx_en,
    input logic                        tx_req,
    input logic                        tx_ack,
    input logic                        uart_tx
);

    int fail_count = 0;     // failed checks so far

    ack_needs_req: assert property (@(posedge clk) disable iff (!resetn)
        $rose(tx_ack) |-> tx_req)
    else
    begin
        $error("tx_ack rose while tx_req was low");
        fail_count++;
    end

    idle_when_off: assert property (@(posedge clk) disable iff (!resetn)
        !tx_en |=> uart_tx)
    else
    begin
        $error("uart_tx not high the cycle after the transmitter was disabled");
        fail_count++;
    end

    quiet_bus: assert property (@(posedge clk) disable iff (!resetn)
        !bus.sel |-> (rdata == '0))
    else
    begin
        $error("rdata not zero while sel is low");
        fail_count++;
    end

endmodule : uart_assertions

// tx signals are taken at the top, where the transmitter ports are wired
bind uart_top uart_assertions asrt_i
(
    .clk     (clk),
    .resetn  (resetn),
    .bus     (bus),
    .rdata   (rdata),
    .tx_en   (tx_en),
    .tx_req  (tx_req),
    .tx_ack  (tx_ack),
    .uart_tx (uart_tx)
);

`default_nettype wire

// File: test/uart_tb.sv
// uart testbench reading cases from a file, driving the bus and checking the responses
`timescale 1ns/1ns
`default_nettype none

module uart_tb;

    localparam logic [15:0] cr_tx_en = 16'h0001;
    localparam logic [15:0] cr_rx_en = 16'h0002;
    localparam logic [15:0] cr_busy  = 16'h0004;
    localparam logic [15:0] cr_valid = 16'h0008;
    localparam logic [15:0] cr_ferr  = 16'h0010;

    typedef struct packed {
        logic [7:0]  mode;          // 0 loopback, 1 injected, 2 abort
        logic [15:0] bauds;
        logic [7:0]  data;
        logic        stop;          // stop bit level of an injected frame
        logic [7:0]  exp_data;
        logic        exp_ferr;
    } case_t;

    logic                        clk;
    logic                        resetn;
    uart_pkg::uart_bus_req_t     bus;
    logic [uart_pkg::data_w-1:0] rdata;
    logic                        uart_tx;
    logic                        rx_line;
    logic                        rx_drv;       // line driven by the testbench
    logic                        loop_en;
    case_t                       cases[$];
    logic [31:0]                 lcg_state;
    int                          cycles = 0;
    int                          limit = 0;

    assign rx_line = loop_en ? uart_tx : rx_drv;

    uart_clk_gen clk_gen_i (.clk(clk), .resetn(resetn));

    uart_top dut_i
    (
        .clk     (clk),
        .resetn  (resetn),
        .bus     (bus),
        .uart_rx (rx_line),
        .rdata   (rdata),
        .uart_tx (uart_tx)
    );

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if ((limit > 0) && (cycles >= limit))
        begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            stop_with_failure();
        end
        assert (dut_i.asrt_i.fail_count == 0)
        else
        begin
            $display("A protocol check on the DUT failed");
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
        assert (got === exp)
        else
        begin
            $display("Mismatch %s: got 0x%04h, expected 0x%04h", name, got, exp);
            stop_with_failure();
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic idle_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic bus_write(input logic [1:0] addr, input logic [15:0] data);
        bus.sel   = 1'b1;
        bus.we    = 1'b1;
        bus.addr  = addr;
        bus.wdata = data;
        idle_cycle();               // write lands on this edge
        bus = '0;
    endtask

    task automatic bus_read(input logic [1:0] addr, output logic [15:0] data);
        bus.sel  = 1'b1;
        bus.we   = 1'b0;
        bus.addr = addr;
        @(negedge clk);
        data = rdata;
        idle_cycle();
        bus = '0;
    endtask

    task automatic wait_status(input logic [15:0] mask, input logic [15:0] value);
        logic [15:0] rd;
        bus_read(uart_pkg::addr_cr, rd);
        while ((rd & mask) != value)
            bus_read(uart_pkg::addr_cr, rd);
    endtask

    task automatic send_frame(input logic [15:0] b, input logic [7:0] d, input logic stop);
        logic [9:0] bits;
        bits = {stop, d, 1'b0};     // start bit first, lsb first
        for (int i = 0; i < 10; i++)
        begin
            rx_drv = bits[i];
            repeat (b + 1) idle_cycle();
        end
        rx_drv = 1'b1;
    endtask

    task automatic check_rx(input case_t c, input logic [15:0] en);
        logic [15:0] rd;
        wait_status(cr_busy | cr_valid, cr_valid);
        bus_read(uart_pkg::addr_cr, rd);
        check_val("cr", rd, en | cr_valid | (c.exp_ferr ? cr_ferr : 16'h0000));
        bus_read(uart_pkg::addr_rxd, rd);
        check_val("rxd", rd, {8'h00, c.exp_data});
        bus_read(uart_pkg::addr_cr, rd);
        check_val("rx_valid", rd & cr_valid, 16'h0000);
        if (c.exp_ferr)
        begin
            bus_write(uart_pkg::addr_cr, en | cr_ferr);     // sticky bit, write 1 clears
            bus_read(uart_pkg::addr_cr, rd);
            check_val("frame_err", rd & cr_ferr, 16'h0000);
        end
    endtask

    task automatic run_loopback(input case_t c);
        logic [15:0] rd;
        int          cnt;
        loop_en = 1'b1;
        bus_write(uart_pkg::addr_bauds, c.bauds);
        bus_write(uart_pkg::addr_cr, cr_tx_en | cr_rx_en);
        bus_write(uart_pkg::addr_txd, {8'h00, c.data});
        bus_read(uart_pkg::addr_cr, rd);
        check_val("tx_busy", rd & cr_busy, cr_busy);
        lcg_state = lcg_next(lcg_state);
        bus_write(uart_pkg::addr_txd, {8'h00, lcg_state[23:16]});  // busy, must be dropped
        while (uart_tx)
            idle_cycle();
        cnt = 0;
        while (!uart_tx)
        begin
            cnt++;
            idle_cycle();
        end
        if (c.data[0])              // a low bit 0 would stretch the low time
            check_val("start bit cycles", cnt[15:0], c.bauds + 16'd1);
        check_rx(c, cr_tx_en | cr_rx_en);
        bus_read(uart_pkg::addr_txd, rd);
        check_val("txd", rd, {8'h00, c.data});
    endtask

    task automatic run_inject(input case_t c);
        loop_en = 1'b0;
        bus_write(uart_pkg::addr_bauds, c.bauds);
        bus_write(uart_pkg::addr_cr, cr_rx_en);
        send_frame(c.bauds, c.data, c.stop);
        check_rx(c, cr_rx_en);
    endtask

    task automatic run_tx_abort(input case_t c);
        logic [15:0] rd;
        loop_en = 1'b0;
        bus_write(uart_pkg::addr_bauds, c.bauds);
        bus_write(uart_pkg::addr_cr, cr_tx_en);
        bus_write(uart_pkg::addr_txd, {8'h00, c.data});
        while (uart_tx)
            idle_cycle();
        repeat (3 * (c.bauds + 1)) idle_cycle();   // into the data bits
        bus_write(uart_pkg::addr_cr, 16'h0000);
        idle_cycle();
        check_val("uart_tx", uart_tx, 16'h0001);
        bus_read(uart_pkg::addr_cr, rd);
        check_val("tx_busy", rd & cr_busy, 16'h0000);
        lcg_state = lcg_next(lcg_state);
        bus_write(uart_pkg::addr_txd, {8'h00, lcg_state[23:16]});
        bus_write(uart_pkg::addr_cr, cr_tx_en);
        repeat (10 * (c.bauds + 1))
        begin
            check_val("uart_tx", uart_tx, 16'h0001);
            idle_cycle();
        end
    endtask

    initial
    begin
        int          fd;
        int          m, b, d, s, e, f;
        int          max_b;
        string       line;
        case_t       c;
        logic [15:0] rd;
        bus       = '0;
        rx_drv    = 1'b1;
        loop_en   = 1'b0;
        lcg_state = 32'h2dfa359f;
        max_b     = 0;
        fd = $fopen("test/uart_cases.txt", "r");
        assert (fd != 0)
        else
        begin
            $display("Could not open the case file test/uart_cases.txt");
            stop_with_failure();
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "%h %h %h %h %h %h", m, b, d, s, e, f) == 6)
            begin
                c.mode     = m[7:0];
                c.bauds    = b[15:0];
                c.data     = d[7:0];
                c.stop     = s[0];
                c.exp_data = e[7:0];
                c.exp_ferr = f[0];
                cases.push_back(c);
                if (b > max_b)
                    max_b = b;
            end
        end
        $fclose(fd);
        assert (cases.size() > 0)
        else
        begin
            $display("The case file holds no test cases");
            stop_with_failure();
        end
        limit = cases.size() * 12 * 10 * (max_b + 1) + 1000;

        @(posedge resetn);
        idle_cycle();
        check_val("uart_tx", uart_tx, 16'h0001);
        bus_read(uart_pkg::addr_cr, rd);
        check_val("cr", rd, 16'h0000);
        bus_read(uart_pkg::addr_bauds, rd);
        check_val("bauds", rd, 16'h0000);

        foreach (cases[i])
        begin
            case (cases[i].mode)
                8'd0:    run_loopback(cases[i]);
                8'd1:    run_inject(cases[i]);
                default: run_tx_abort(cases[i]);
            endcase
        end

        if (dut_i.asrt_i.fail_count == 0)
        begin
            $display("Simulation PASSED");
            $finish;
        end
        else
        begin
            $display("Protocol checks failed %0d times", dut_i.asrt_i.fail_count);
            stop_with_failure();
        end
    end

endmodule : uart_tb

`default_nettype wire

// File: uart_top.f
verilog/uart_pkg.sv
verilog/uart_transmitter.sv
verilog/uart_receiver.sv
verilog/uart_regs.sv
verilog/uart_top.sv
test/uart_clk_gen.sv
test/uart_assertions.sv
test/uart_tb.sv

// File: test/uart_cases.txt
# mode bauds byte stop exp_byte exp_ferr, all in hex
# mode 0 loopback, 1 injected frame, 2 abort (stop and expected columns unused for abort)
0 0007 a5 1 a5 0
0 000f 3b 1 3b 0
1 0009 c3 1 c3 0
1 000b 5e 0 5e 1
0 001f 81 1 81 0
2 000a 77 1 00 0
0 0005 0f 1 0f 0
1 0014 99 0 99 1
2 0007 e1 1 00 0
0 0014 ff 1 ff 0
1 0003 01 1 01 0
0 0003 55 1 55 0
